// File: sources.f
design/rob_pkg.sv
design/rob_csr_pkg.sv
design/rob_entries.sv
design/arch_regfile.sv
design/rob_csr.sv
design/rob_top.sv
test/tb_clock.sv
test/rob_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= rob_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check the log for the pass line"
	@echo "  clean  remove build output and the log"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	grep -q '\*\*\* PASSED \*\*\*' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: test/rob_tb.sv
`timescale 1ns/10ps

module rob_tb;

    // six tests take a few hundred cycles together
    localparam int max_cycles = 2000;

    logic clk;
    logic rst;
    rob_pkg::alloc_req_t  alloc;
    rob_pkg::alloc_rsp_t  alloc_rsp;
    rob_pkg::complete_t   complete;
    rob_pkg::commit_t     commit;
    rob_pkg::redirect_t   redirect;
    rob_pkg::reg_addr_t   rs_addr;
    rob_pkg::operand_t    operand;
    rob_csr_pkg::wb_req_t wb_req;
    rob_csr_pkg::wb_rsp_t wb_rsp;

    rob_pkg::commit_t   commits [$];
    rob_pkg::redirect_t redirs [$];
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    logic [31:0] rng = 32'h172d8566;

    tb_clock u_clock (.clk(clk));

    rob_top i_rob_top (
        .clk(clk), .rst(rst), .alloc(alloc), .alloc_rsp(alloc_rsp), .complete(complete),
        .commit(commit), .redirect(redirect), .rs_addr(rs_addr), .operand(operand),
        .wb_req(wb_req), .wb_rsp(wb_rsp)
    );

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout: the tests did not finish within %0d cycles", max_cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // commit outputs depend on registered state only
    always @(negedge clk) begin
        if (!rst && commit.valid === 1'b1) begin
            commits.push_back(commit);
            redirs.push_back(redirect);
        end
    end

    function automatic logic [31:0] lcg_next();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng;
    endfunction

    function automatic rob_pkg::alloc_rsp_t alloc_result(logic grant, rob_pkg::tag_t tag);
        rob_pkg::alloc_rsp_t r;
        r.grant = grant;
        r.tag = tag;
        return r;
    endfunction

    function automatic rob_pkg::commit_t retired(rob_pkg::entry_kind_t kind,
            rob_pkg::tag_t tag, rob_pkg::reg_addr_t rd, rob_pkg::word_t w);
        rob_pkg::commit_t c;
        c.valid = 1'b1;
        c.kind = kind;
        c.tag = tag;
        c.rd = rd;
        c.payload.data = w;
        return c;
    endfunction

    function automatic rob_pkg::redirect_t redirect_of(logic valid, rob_pkg::word_t pc);
        rob_pkg::redirect_t r;
        r.valid = valid;
        r.pc = pc;
        return r;
    endfunction

    task automatic check_rsp(input rob_pkg::alloc_rsp_t got, input rob_pkg::alloc_rsp_t exp,
            input string msg);
        checks++;
        // tag is meaningless without a grant
        if (got.grant !== exp.grant || (exp.grant && got.tag !== exp.tag)) begin
            errors++;
            $display("Fail at %0t: %s: got %h, expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_commit(input rob_pkg::commit_t got, input rob_pkg::commit_t exp,
            input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s: got %h, expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_redirect(input rob_pkg::redirect_t got, input rob_pkg::redirect_t exp,
            input string msg);
        checks++;
        if (got.valid !== exp.valid || (exp.valid && got.pc !== exp.pc)) begin
            errors++;
            $display("Fail at %0t: %s: got %h, expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_operand(input rob_pkg::operand_t got, input rob_pkg::operand_t exp,
            input string msg);
        checks++;
        // owner counts while busy, value once free
        if (got.busy !== exp.busy
                || (exp.busy ? got.owner !== exp.owner : got.value !== exp.value)) begin
            errors++;
            $display("Fail at %0t: %s: got %h, expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s: got %h, expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic do_reset();
        @(negedge clk);
        rst = 1'b1;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        commits.delete();
        redirs.delete();
    endtask

    task automatic alloc_one(input rob_pkg::entry_kind_t kind, input rob_pkg::reg_addr_t rd,
            input logic pred, input rob_pkg::alloc_rsp_t exp);
        @(negedge clk);
        alloc.valid = 1'b1;
        alloc.kind = kind;
        alloc.rd = rd;
        alloc.pred_taken = pred;
        #1;
        check_rsp(alloc_rsp, exp, "allocation response");
        @(negedge clk);
        alloc.valid = 1'b0;
    endtask

    task automatic complete_one(input rob_pkg::tag_t tag, input logic taken,
            input rob_pkg::word_t w);
        @(negedge clk);
        complete.valid = 1'b1;
        complete.tag = tag;
        complete.taken = taken;
        complete.payload.data = w;
        @(negedge clk);
        complete.valid = 1'b0;
    endtask

    task automatic look_up(input rob_pkg::reg_addr_t r, input logic busy,
            input rob_pkg::tag_t owner, input rob_pkg::word_t value, input string msg);
        rob_pkg::operand_t exp;
        exp.busy = busy;
        exp.owner = owner;
        exp.value = value;
        @(negedge clk);
        rs_addr = r;
        #1;
        check_operand(operand, exp, msg);
    endtask

    task automatic wb_cycle(input logic we, input logic [3:0] adr, input logic [31:0] dat,
            output logic [31:0] rdata);
        @(negedge clk);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we = we;
        wb_req.adr = adr;
        wb_req.dat = dat;
        do @(negedge clk); while (wb_rsp.ack !== 1'b1);
        rdata = wb_rsp.dat;
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we = 1'b0;
    endtask

    task automatic wb_write(input logic [3:0] adr, input logic [31:0] dat);
        logic [31:0] unused;
        wb_cycle(1'b1, adr, dat, unused);
    endtask

    task automatic wb_expect(input logic [3:0] adr, input logic [31:0] exp, input string msg);
        logic [31:0] rdata;
        wb_cycle(1'b0, adr, 32'h0, rdata);
        check_word(rdata, exp, msg);
    endtask

    task automatic wait_commits(input int n);
        while (commits.size() < n) @(negedge clk);
    endtask

    task automatic end_test(input string name, input int start);
        if (errors == start) $display("test %s: ok", name);
        else $display("test %s: %0d errors", name, errors - start);
    endtask

    task automatic test_allocation();
        int start;
        start = errors;
        do_reset();
        for (int i = 0; i < rob_pkg::rob_depth; i++) begin
            alloc_one(rob_pkg::store, 5'd0, 1'b0, alloc_result(1'b1, rob_pkg::tag_t'(i)));
        end
        wb_expect(rob_csr_pkg::csr_status, 32'h0000_0110, "status when full");
        alloc_one(rob_pkg::store, 5'd0, 1'b0, alloc_result(1'b0, 4'd0));
        end_test("allocation", start);
    endtask

    task automatic test_in_order();
        int start;
        int order [8];
        rob_pkg::word_t data [8];
        int j;
        int tmp;
        start = errors;
        do_reset();
        for (int i = 0; i < 8; i++) begin
            order[i] = i;
            data[i] = lcg_next();
            alloc_one(rob_pkg::reg_write, 5'(i + 1), 1'b0, alloc_result(1'b1, 4'(i)));
        end
        for (int i = 7; i > 0; i--) begin
            j = int'(lcg_next() % 32'(i + 1));
            tmp = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < 8; i++) complete_one(4'(order[i]), 1'b0, data[order[i]]);
        wait_commits(8);
        for (int i = 0; i < 8; i++) begin
            check_commit(commits[i], retired(rob_pkg::reg_write, 4'(i), 5'(i + 1), data[i]),
                         "commit order");
            look_up(5'(i + 1), 1'b0, 4'd0, data[i], "register after commit");
        end
        end_test("in-order commit", start);
    endtask

    task automatic test_rename();
        int start;
        rob_pkg::word_t d1;
        rob_pkg::word_t d2;
        start = errors;
        d1 = lcg_next();
        d2 = lcg_next();
        do_reset();
        alloc_one(rob_pkg::reg_write, 5'd5, 1'b0, alloc_result(1'b1, 4'd0));
        alloc_one(rob_pkg::reg_write, 5'd5, 1'b0, alloc_result(1'b1, 4'd1));
        alloc_one(rob_pkg::reg_write, 5'd0, 1'b0, alloc_result(1'b1, 4'd2));
        look_up(5'd5, 1'b1, 4'd1, 32'h0, "younger owner before commit");
        look_up(5'd0, 1'b0, 4'd0, 32'h0, "x0 before commit");
        complete_one(4'd0, 1'b0, d1);
        wait_commits(1);
        look_up(5'd5, 1'b1, 4'd1, 32'h0, "owner after older commit");
        complete_one(4'd1, 1'b0, d2);
        wait_commits(2);
        look_up(5'd5, 1'b0, 4'd0, d2, "value after younger commit");
        complete_one(4'd2, 1'b0, lcg_next());
        wait_commits(3);
        look_up(5'd0, 1'b0, 4'd0, 32'h0, "x0 after commit");
        end_test("rename ownership", start);
    endtask

    task automatic test_store_branch();
        int start;
        rob_pkg::word_t v;
        rob_pkg::word_t w;
        rob_pkg::word_t pc;
        start = errors;
        v = lcg_next();
        w = lcg_next();
        pc = lcg_next() & 32'hffff_fffc;
        do_reset();
        alloc_one(rob_pkg::reg_write, 5'd7, 1'b0, alloc_result(1'b1, 4'd0));
        complete_one(4'd0, 1'b0, v);
        alloc_one(rob_pkg::store, 5'd7, 1'b0, alloc_result(1'b1, 4'd1));
        complete_one(4'd1, 1'b0, w);
        alloc_one(rob_pkg::branch, 5'd0, 1'b1, alloc_result(1'b1, 4'd2));
        complete_one(4'd2, 1'b1, pc);
        wait_commits(3);
        check_commit(commits[1], retired(rob_pkg::store, 4'd1, 5'd7, w), "store release");
        check_commit(commits[2], retired(rob_pkg::branch, 4'd2, 5'd0, pc), "branch commit");
        for (int i = 0; i < 3; i++) begin
            check_redirect(redirs[i], redirect_of(1'b0, 32'h0), "no redirect");
        end
        look_up(5'd7, 1'b0, 4'd0, v, "register kept after store");
        end_test("store and branch", start);
    endtask

    task automatic test_mispredict();
        int start;
        rob_pkg::word_t v1;
        rob_pkg::word_t v2;
        rob_pkg::word_t pc;
        start = errors;
        v1 = lcg_next();
        v2 = lcg_next();
        pc = lcg_next() & 32'hffff_fffc;
        do_reset();
        alloc_one(rob_pkg::reg_write, 5'd9, 1'b0, alloc_result(1'b1, 4'd0));
        alloc_one(rob_pkg::reg_write, 5'd10, 1'b0, alloc_result(1'b1, 4'd1));
        complete_one(4'd0, 1'b0, v1);
        complete_one(4'd1, 1'b0, v2);
        wait_commits(2);
        alloc_one(rob_pkg::branch, 5'd0, 1'b0, alloc_result(1'b1, 4'd2));
        alloc_one(rob_pkg::reg_write, 5'd9, 1'b0, alloc_result(1'b1, 4'd3));
        alloc_one(rob_pkg::reg_write, 5'd10, 1'b0, alloc_result(1'b1, 4'd4));
        complete_one(4'd3, 1'b0, lcg_next());
        complete_one(4'd4, 1'b0, lcg_next());
        look_up(5'd9, 1'b1, 4'd3, 32'h0, "younger rename before mispredict");
        complete_one(4'd2, 1'b1, pc);
        wait_commits(3);
        check_commit(commits[2], retired(rob_pkg::branch, 4'd2, 5'd0, pc), "branch commit");
        check_redirect(redirs[2], redirect_of(1'b1, pc), "redirect pc");
        // younger entries must stay gone
        repeat (4) @(negedge clk);
        check_word(32'(commits.size()), 32'd3, "commits after mispredict");
        wb_expect(rob_csr_pkg::csr_status, 32'h0, "status after mispredict");
        look_up(5'd9, 1'b0, 4'd0, v1, "register 9 after flush");
        look_up(5'd10, 1'b0, 4'd0, v2, "register 10 after flush");
        wb_expect(rob_csr_pkg::csr_flushes, 32'd1, "redirect counter");
        end_test("mispredict", start);
    endtask

    task automatic test_csr();
        int start;
        rob_pkg::word_t d [3];
        start = errors;
        do_reset();
        wb_write(rob_csr_pkg::csr_ctrl, 32'h0);
        for (int i = 0; i < 3; i++) begin
            d[i] = lcg_next();
            alloc_one(rob_pkg::reg_write, 5'(11 + i), 1'b0, alloc_result(1'b1, 4'(i)));
        end
        complete_one(4'd2, 1'b0, d[2]);
        complete_one(4'd0, 1'b0, d[0]);
        complete_one(4'd1, 1'b0, d[1]);
        repeat (4) @(negedge clk);
        check_word(32'(commits.size()), 32'd0, "commits while disabled");
        wb_expect(rob_csr_pkg::csr_status, 32'd3, "status while held");
        wb_write(rob_csr_pkg::csr_ctrl, 32'h1);
        wait_commits(3);
        for (int i = 0; i < 3; i++) begin
            check_commit(commits[i], retired(rob_pkg::reg_write, 4'(i), 5'(11 + i), d[i]),
                         "release order");
        end
        wb_expect(rob_csr_pkg::csr_commits, 32'(commits.size()), "commit counter");
        alloc_one(rob_pkg::reg_write, 5'd11, 1'b0, alloc_result(1'b1, 4'd3));
        alloc_one(rob_pkg::store, 5'd0, 1'b0, alloc_result(1'b1, 4'd4));
        look_up(5'd11, 1'b1, 4'd3, 32'h0, "rename before software flush");
        wb_expect(rob_csr_pkg::csr_status, 32'd2, "status before software flush");
        wb_write(rob_csr_pkg::csr_ctrl, 32'h3);
        wb_expect(rob_csr_pkg::csr_status, 32'd0, "status after software flush");
        // flushed tags must ignore late completions
        complete_one(4'd3, 1'b0, lcg_next());
        complete_one(4'd4, 1'b0, lcg_next());
        repeat (4) @(negedge clk);
        look_up(5'd11, 1'b0, 4'd0, d[0], "register after software flush");
        check_word(32'(commits.size()), 32'd3, "commits after software flush");
        end_test("register block", start);
    endtask

    initial begin
        rst = 1'b1;
        alloc = '0;
        complete = '0;
        rs_addr = '0;
        wb_req = '0;
        test_allocation();
        test_in_order();
        test_rename();
        test_store_branch();
        test_mispredict();
        test_csr();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: test/tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
    output logic clk
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

endmodule

// File: design/rob_top.sv
`timescale 1ns/10ps

module rob_top (
    input  logic                 clk,
    input  logic                 rst,
    input  rob_pkg::alloc_req_t  alloc,
    output rob_pkg::alloc_rsp_t  alloc_rsp,
    input  rob_pkg::complete_t   complete,
    output rob_pkg::commit_t     commit,
    output rob_pkg::redirect_t   redirect,
    input  rob_pkg::reg_addr_t   rs_addr,
    output rob_pkg::operand_t    operand,
    input  rob_csr_pkg::wb_req_t wb_req,
    output rob_csr_pkg::wb_rsp_t wb_rsp
);

    logic [4:0] count;
    logic       full;
    logic       commit_en;
    logic       sw_flush;
    logic       rf_flush;

    // rename state is dropped on either kind of flush
    assign rf_flush = sw_flush || redirect.valid;

    rob_entries u_entries (
        .clk       (clk),
        .rst       (rst),
        .alloc     (alloc),
        .alloc_rsp (alloc_rsp),
        .complete  (complete),
        .commit_en (commit_en),
        .flush     (sw_flush),
        .commit    (commit),
        .redirect  (redirect),
        .count     (count),
        .full      (full)
    );

    arch_regfile u_regfile (
        .clk       (clk),
        .rst       (rst),
        .alloc     (alloc),
        .alloc_rsp (alloc_rsp),
        .commit    (commit),
        .flush     (rf_flush),
        .rs_addr   (rs_addr),
        .operand   (operand)
    );

    rob_csr u_csr (
        .clk       (clk),
        .rst       (rst),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .count     (count),
        .full      (full),
        .commit    (commit),
        .redirect  (redirect),
        .commit_en (commit_en),
        .flush     (sw_flush)
    );

endmodule

// File: design/rob_csr.sv
`timescale 1ns/10ps

module rob_csr (
    input  logic                 clk,
    input  logic                 rst,
    input  rob_csr_pkg::wb_req_t wb_req,
    output rob_csr_pkg::wb_rsp_t wb_rsp,
    input  logic [4:0]           count,
    input  logic                 full,
    input  rob_pkg::commit_t     commit,
    input  rob_pkg::redirect_t   redirect,
    output logic                 commit_en,
    output logic                 flush
);

    logic        access;
    logic        wr;
    logic        ack_q;
    logic [31:0] dat_q;
    logic [31:0] rd_data;
    logic        commit_en_q;
    logic        flush_q;
    logic [31:0] commits_q;
    logic [31:0] redirects_q;

    // accept only while ack is low
    assign access = wb_req.cyc && wb_req.stb && !ack_q;
    assign wr = access && wb_req.we;

    always_comb begin
        rd_data = '0;
        case (wb_req.adr)
            rob_csr_pkg::csr_ctrl: begin
                rd_data[rob_csr_pkg::ctrl_commit_en] = commit_en_q;
                rd_data[rob_csr_pkg::ctrl_flush] = flush_q;
            end
            rob_csr_pkg::csr_status: begin
                rd_data[4:0] = count;
                rd_data[8] = full;
            end
            rob_csr_pkg::csr_commits: rd_data = commits_q;
            rob_csr_pkg::csr_flushes: rd_data = redirects_q;
            default: rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q <= 1'b0;
            commit_en_q <= rob_csr_pkg::ctrl_reset[rob_csr_pkg::ctrl_commit_en];
            flush_q <= rob_csr_pkg::ctrl_reset[rob_csr_pkg::ctrl_flush];
        end else begin
            ack_q <= access;
            // flush bit clears itself after one cycle
            flush_q <= 1'b0;
            if (wr && wb_req.adr == rob_csr_pkg::csr_ctrl) begin
                commit_en_q <= wb_req.dat[rob_csr_pkg::ctrl_commit_en];
                flush_q <= wb_req.dat[rob_csr_pkg::ctrl_flush];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            dat_q <= rd_data;
        end
    end

    // each counter clears on a write to its own offset
    always_ff @(posedge clk) begin
        if (rst || (wr && wb_req.adr == rob_csr_pkg::csr_commits)) begin
            commits_q <= '0;
        end else if (commit.valid) begin
            commits_q <= commits_q + 1'b1;
        end
        if (rst || (wr && wb_req.adr == rob_csr_pkg::csr_flushes)) begin
            redirects_q <= '0;
        end else if (redirect.valid) begin
            redirects_q <= redirects_q + 1'b1;
        end
    end

    always_comb begin
        wb_rsp.ack = ack_q;
        wb_rsp.dat = dat_q;
    end

    assign commit_en = commit_en_q;
    assign flush = flush_q;

endmodule

// File: design/arch_regfile.sv
`timescale 1ns/10ps

module arch_regfile (
    input  logic                clk,
    input  logic                rst,
    input  rob_pkg::alloc_req_t alloc,
    input  rob_pkg::alloc_rsp_t alloc_rsp,
    input  rob_pkg::commit_t    commit,
    input  logic                flush,
    input  rob_pkg::reg_addr_t  rs_addr,
    output rob_pkg::operand_t   operand
);

    rob_pkg::word_t regs_q  [rob_pkg::arch_regs];
    rob_pkg::tag_t  owner_q [rob_pkg::arch_regs];
    logic [rob_pkg::arch_regs-1:0] busy_q;

    logic commit_wr;
    logic rename;
    logic release_owner;

    // x0 is never written or renamed
    assign commit_wr = commit.valid && (commit.kind == rob_pkg::reg_write)
                       && (commit.rd != '0);
    assign rename = alloc_rsp.grant && (alloc.kind == rob_pkg::reg_write)
                    && (alloc.rd != '0);
    assign release_owner = commit_wr && (owner_q[commit.rd] == commit.tag);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            busy_q <= '0;
        end else begin
            if (release_owner) begin
                busy_q[commit.rd] <= 1'b0;
            end
            // a new rename of the same register wins
            if (rename) begin
                busy_q[alloc.rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rename) begin
            owner_q[alloc.rd] <= alloc_rsp.tag;
        end
        if (commit_wr) begin
            regs_q[commit.rd] <= commit.payload.data;
        end
    end

    always_comb begin
        operand.busy = 1'b0;
        operand.owner = '0;
        operand.value = '0;
        if (rs_addr != '0) begin
            operand.busy = busy_q[rs_addr];
            operand.owner = owner_q[rs_addr];
            operand.value = regs_q[rs_addr];
        end
    end

endmodule

// File: design/rob_entries.sv
`timescale 1ns/10ps

module rob_entries (
    input  logic                clk,
    input  logic                rst,
    input  rob_pkg::alloc_req_t alloc,
    output rob_pkg::alloc_rsp_t alloc_rsp,
    input  rob_pkg::complete_t  complete,
    input  logic                commit_en,
    input  logic                flush,
    output rob_pkg::commit_t    commit,
    output rob_pkg::redirect_t  redirect,
    output logic [4:0]          count,
    output logic                full
);

    rob_pkg::entry_kind_t kind_q    [rob_pkg::rob_depth];
    rob_pkg::reg_addr_t   rd_q      [rob_pkg::rob_depth];
    logic                 pred_q    [rob_pkg::rob_depth];
    logic                 taken_q   [rob_pkg::rob_depth];
    rob_pkg::payload_u    payload_q [rob_pkg::rob_depth];

    logic [rob_pkg::rob_depth-1:0] occ_q;
    logic [rob_pkg::rob_depth-1:0] done_q;

    rob_pkg::tag_t head_q;
    rob_pkg::tag_t tail_q;
    logic [4:0]    count_q;

    logic grant;
    logic retire;
    logic mispredict;
    logic clear;
    logic accept_complete;

    assign full = (count_q == 5'(rob_pkg::rob_depth));
    assign count = count_q;

    // head retires when finished and commit is on
    assign retire = occ_q[head_q] && done_q[head_q] && commit_en;
    assign mispredict = retire && (kind_q[head_q] == rob_pkg::branch)
                        && (taken_q[head_q] != pred_q[head_q]);
    assign clear = flush || mispredict;

    assign grant = alloc.valid && !full && !clear;
    assign accept_complete = complete.valid && occ_q[complete.tag];

    always_comb begin
        alloc_rsp.grant = grant;
        alloc_rsp.tag = tail_q;
    end

    always_comb begin
        commit.valid = retire;
        commit.kind = kind_q[head_q];
        commit.tag = head_q;
        commit.rd = rd_q[head_q];
        commit.payload = payload_q[head_q];
    end

    always_comb begin
        redirect.valid = mispredict;
        redirect.pc = payload_q[head_q].next_pc;
    end

    // pointers, occupancy and completion flags
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            occ_q <= '0;
            done_q <= '0;
            head_q <= '0;
            tail_q <= '0;
            count_q <= '0;
        end else begin
            if (accept_complete) begin
                done_q[complete.tag] <= 1'b1;
            end
            if (retire) begin
                occ_q[head_q] <= 1'b0;
                done_q[head_q] <= 1'b0;
                head_q <= head_q + 1'b1;
            end
            if (grant) begin
                occ_q[tail_q] <= 1'b1;
                done_q[tail_q] <= 1'b0;
                tail_q <= tail_q + 1'b1;
            end
            case ({grant, retire})
                2'b10: count_q <= count_q + 1'b1;
                2'b01: count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // entry contents
    always_ff @(posedge clk) begin
        if (grant) begin
            kind_q[tail_q] <= alloc.kind;
            rd_q[tail_q] <= alloc.rd;
            pred_q[tail_q] <= alloc.pred_taken;
        end
        if (accept_complete) begin
            taken_q[complete.tag] <= complete.taken;
            payload_q[complete.tag] <= complete.payload;
        end
    end

endmodule

// File: design/rob_csr_pkg.sv
package rob_csr_pkg;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  adr;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // word offsets
    localparam logic [3:0] csr_ctrl    = 4'd0;
    localparam logic [3:0] csr_status  = 4'd1;
    localparam logic [3:0] csr_commits = 4'd2;
    localparam logic [3:0] csr_flushes = 4'd3;

    localparam int ctrl_commit_en = 0;
    localparam int ctrl_flush     = 1;

    // commit enabled out of reset
    localparam logic [31:0] ctrl_reset = 32'h0000_0001;

endpackage

// File: design/rob_pkg.sv
package rob_pkg;

    // buffer and register file sizes
    localparam int rob_depth = 16;
    localparam int arch_regs = 32;

    typedef logic [3:0]  tag_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] word_t;

    typedef enum logic [1:0] {
        reg_write = 2'd0,
        store     = 2'd1,
        branch    = 2'd2
    } entry_kind_t;

    // one completion word, read by entry kind
    typedef union packed {
        word_t data;
        word_t next_pc;
    } payload_u;

    typedef struct packed {
        logic        valid;
        entry_kind_t kind;
        reg_addr_t   rd;
        logic        pred_taken;
    } alloc_req_t;

    typedef struct packed {
        logic grant;
        tag_t tag;
    } alloc_rsp_t;

    typedef struct packed {
        logic     valid;
        tag_t     tag;
        logic     taken;
        payload_u payload;
    } complete_t;

    // retired entry
    typedef struct packed {
        logic        valid;
        entry_kind_t kind;
        tag_t        tag;
        reg_addr_t   rd;
        payload_u    payload;
    } commit_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
    } redirect_t;

    typedef struct packed {
        logic  busy;
        tag_t  owner;
        word_t value;
    } operand_t;

endpackage
